// ==== hdl/daq_settings.svh ====
`ifndef DAQ_SETTINGS_SVH
`define DAQ_SETTINGS_SVH

// channel and capacitor group layout
`define DAQ_NCH       16
`define DAQ_NGRP      6

// fifo depths, in words
`define DAQ_CH_DEPTH  64
`define DAQ_HDR_DEPTH 16

// width of SAMP_MAX and the sample counter
`define DAQ_SAMP_W    7

`endif

// ==== hdl/daq_pkg.sv ====
package daq_pkg;

	////////////////////
	// sample path types
	////////////////////

	typedef logic [11:0] adc_word_t;  // one adc sample

	typedef logic [2:0] grp_sel_t;    // capacitor group 0..5

	////////////////////
	// event header
	////////////////////

	// 44 bits, msb first as it leaves the header fifo
	typedef struct packed {
		logic        multi_ovlp;  // more than one event ahead
		logic        ovlp;        // at least one event ahead
		logic        smp_phase;   // SMPCLK level at the match
		logic        ch_full;     // a channel fifo was full at start
		logic [3:0]  ovlp_cnt;    // outstanding events before this one
		logic [11:0] match_cnt;
		logic [23:0] l1a_cnt;
	} l1a_hdr_t;

endpackage

// ==== hdl/load_if.sv ====
// link between load controller, tracker and channel bank
interface load_if;

	logic               pending;    // events waiting or loading
	logic               load_done;  // one pulse per finished event
	daq_pkg::grp_sel_t  sel;        // capacitor group for this sample
	logic               wren;       // write strobe to channel fifos

	modport ctrl (
		input  pending,
		output load_done,
		output sel,
		output wren
	);

	modport trk (
		output pending,
		input  load_done
	);

	modport bank (
		input  sel,
		input  wren
	);

endinterface

// ==== hdl/sync_fifo.sv ====
module sync_fifo #(
	parameter type data_t = logic [11:0],
	parameter int  DEPTH  = 16
) (
	input  logic  CLK40,
	input  logic  clr,
	input  data_t din,
	input  logic  wr_en,
	input  logic  rd_en,
	output data_t dout,
	output logic  empty,
	output logic  full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	data_t          mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [CW-1:0]  count;
	logic           do_wr;
	logic           do_rd;

	assign do_wr = wr_en & ~full;   // words to a full fifo are lost
	assign do_rd = rd_en & ~empty;

	always_ff @(posedge CLK40) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge CLK40) begin
		if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// first word falls through
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));

	// count stays within the depth
	a_count_max : assert property (@(posedge CLK40) disable iff (clr)
		count <= CW'(DEPTH))
		else $error("fifo count past depth: %0d", count);

endmodule

// ==== hdl/sample_load_ctrl.sv ====
`include "daq_settings.svh"

module sample_load_ctrl (
	input  logic                   CLK40,
	input  logic                   RST_RESYNC,
	input  logic [`DAQ_SAMP_W-1:0] samp_max,  // samples per event minus 1
	load_if.ctrl                   ld
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		DONE
	} state_t;

	state_t                 state;
	logic [`DAQ_SAMP_W-1:0] smp_cnt;
	daq_pkg::grp_sel_t      grp;

	////////////////////
	// sequencer
	////////////////////

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			state   <= IDLE;
			smp_cnt <= '0;
			grp     <= '0;
		end else begin
			case (state)
				IDLE: begin
					smp_cnt <= '0;
					grp     <= '0;
					if (ld.pending)
						state <= LOAD;  // first write next cycle
				end
				LOAD: begin
					if (smp_cnt >= samp_max) begin
						state <= DONE;
					end else begin
						smp_cnt <= smp_cnt + 1'b1;
						// cycle through the six capacitor groups
						if (grp == daq_pkg::grp_sel_t'(`DAQ_NGRP - 1))
							grp <= '0;
						else
							grp <= grp + 1'b1;
					end
				end
				DONE:    state <= IDLE;  // one idle cycle before next event
				default: state <= IDLE;
			endcase
		end
	end

	assign ld.wren      = (state == LOAD);
	assign ld.sel       = grp;
	assign ld.load_done = (state == DONE);

	////////////////////
	// checks
	////////////////////

	// group index reaching the bank must stay in range
	a_sel_range : assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		ld.wren |-> ld.sel < daq_pkg::grp_sel_t'(`DAQ_NGRP))
		else $error("sel out of range while writing: %0d", ld.sel);

	// done pulse stands alone and is followed by a gap
	a_done_gap : assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		ld.load_done |-> !ld.wren ##1 !ld.wren)
		else $error("load_done overlaps a write cycle");

endmodule

// ==== hdl/l1a_tracker.sv ====
module l1a_tracker (
	input  logic              CLK40,
	input  logic              RST_RESYNC,
	input  logic              l1a,
	input  logic              l1a_match,
	input  logic              smpclk,
	input  logic              ch_full,
	output logic [23:0]       l1a_cnt,
	output logic [11:0]       match_cnt,
	output daq_pkg::l1a_hdr_t hdr,
	output logic              hdr_wr,
	load_if.trk               ld
);

	logic        match_d1;
	logic        armed;      // match still waiting for a boundary
	logic        smp_d1;
	logic        smp_d2;
	logic        boundary;
	logic        evt_start;
	logic [3:0]  out_cnt;    // outstanding events
	logic [23:0] cap_l1a;
	logic [11:0] cap_mcnt;
	logic        cap_phase;

	////////////////////
	// trigger counters
	////////////////////

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			l1a_cnt   <= '0;
			match_cnt <= '0;
		end else begin
			if (l1a)
				l1a_cnt <= l1a_cnt + 1'b1;
			if (l1a_match)
				match_cnt <= match_cnt + 1'b1;
		end
	end

	// counts as seen at the match, this match included
	always_ff @(posedge CLK40) begin
		if (l1a_match) begin
			cap_l1a   <= l1a_cnt + 24'(l1a);
			cap_mcnt  <= match_cnt + 12'd1;
			cap_phase <= smpclk;
		end
	end

	////////////////////
	// phase alignment
	////////////////////

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			match_d1 <= 1'b0;
			armed    <= 1'b0;
			smp_d1   <= 1'b0;
			smp_d2   <= 1'b0;
		end else begin
			match_d1 <= l1a_match;
			smp_d1   <= smpclk;
			smp_d2   <= smp_d1;
			armed    <= (armed | match_d1) & ~boundary;  // hold until next boundary
		end
	end

	assign boundary  = smp_d2 & ~smp_d1;  // falling SMPCLK edge
	assign evt_start = (match_d1 | armed) & boundary;

	// saturating outstanding event count
	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			out_cnt <= '0;
		end else begin
			case ({evt_start, ld.load_done})
				2'b10:   if (out_cnt != 4'hf) out_cnt <= out_cnt + 1'b1;
				2'b01:   out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;  // both or neither
			endcase
		end
	end

	assign ld.pending = (out_cnt != 4'd0);

	////////////////////
	// header
	////////////////////

	always_comb begin
		hdr.multi_ovlp = (out_cnt > 4'd1);
		hdr.ovlp       = (out_cnt > 4'd0);
		hdr.smp_phase  = cap_phase;
		hdr.ch_full    = ch_full;
		hdr.ovlp_cnt   = out_cnt;   // events ahead of this one
		hdr.match_cnt  = cap_mcnt;
		hdr.l1a_cnt    = cap_l1a;
	end

	assign hdr_wr = evt_start;  // one push per event

	// a finished load always belongs to a counted event
	a_no_underflow : assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		ld.load_done |-> out_cnt != 4'd0)
		else $error("load_done with no outstanding event");

endmodule

// ==== hdl/channel_bank.sv ====
`include "daq_settings.svh"

module channel_bank (
	input  logic                                            CLK40,
	input  logic                                            fifo_clr,
	input  daq_pkg::adc_word_t [`DAQ_NGRP-1:0][`DAQ_NCH-1:0] grp,
	input  logic [`DAQ_NCH-1:0]                             rd_en,
	output daq_pkg::adc_word_t [`DAQ_NCH-1:0]               dout,
	output logic [`DAQ_NCH-1:0]                             empty,
	output logic                                            any_full,
	load_if.bank                                            ld
);

	daq_pkg::adc_word_t [`DAQ_NCH-1:0] muxout;
	logic [`DAQ_NCH-1:0]               ch_full;

	////////////////////
	// group select
	////////////////////

	always_comb begin
		if (ld.sel < daq_pkg::grp_sel_t'(`DAQ_NGRP))
			muxout = grp[ld.sel];
		else
			muxout = '0;  // unused codes 6 and 7
	end

	////////////////////
	// channel fifos
	////////////////////

	for (genvar ch = 0; ch < `DAQ_NCH; ch++) begin : g_ch
		sync_fifo #(
			.data_t (daq_pkg::adc_word_t),
			.DEPTH  (`DAQ_CH_DEPTH)
		) u_fifo (
			.CLK40  (CLK40),
			.clr    (fifo_clr),
			.din    (muxout[ch]),
			.wr_en  (ld.wren),      // all channels write together
			.rd_en  (rd_en[ch]),
			.dout   (dout[ch]),
			.empty  (empty[ch]),
			.full   (ch_full[ch])
		);
	end

	assign any_full = |ch_full;

endmodule

// ==== hdl/fifo16ch_wide.sv ====
`include "daq_settings.svh"

module fifo16ch_wide (
	input  logic                   CLK40,
	input  logic                   RST_RESYNC,
	input  logic                   FIFO_RST,
	input  logic                   L1A,
	input  logic                   L1A_MATCH,
	input  logic                   SMPCLK,
	input  logic [`DAQ_SAMP_W-1:0] SAMP_MAX,  // samples per event minus 1
	input  logic [191:0]           G1IN,
	input  logic [191:0]           G2IN,
	input  logic [191:0]           G3IN,
	input  logic [191:0]           G4IN,
	input  logic [191:0]           G5IN,
	input  logic [191:0]           G6IN,
	input  logic [`DAQ_NCH-1:0]    RD_ENA,
	input  logic                   L1A_RD_EN,
	output logic                   RDY,
	output logic [43:0]            L1A_SMP_OUT,
	output logic [191:0]           DOUT_16CH,
	output logic [23:0]            L1A_CNT,
	output logic [11:0]            L1A_MTCH_CNT,
	output logic [`DAQ_NCH-1:0]    fmt
);

	load_if ld ();

	daq_pkg::l1a_hdr_t hdr;
	daq_pkg::l1a_hdr_t hdr_out;
	logic              hdr_wr;
	logic              hdr_empty;
	logic              ch_full;
	logic              fifo_clr;

	assign fifo_clr = FIFO_RST | RST_RESYNC;  // either one empties all fifos

	////////////////////
	// control
	////////////////////

	sample_load_ctrl u_ctrl (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.samp_max   (SAMP_MAX),
		.ld         (ld.ctrl)
	);

	l1a_tracker u_trk (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.l1a        (L1A),
		.l1a_match  (L1A_MATCH),
		.smpclk     (SMPCLK),
		.ch_full    (ch_full),
		.l1a_cnt    (L1A_CNT),
		.match_cnt  (L1A_MTCH_CNT),
		.hdr        (hdr),
		.hdr_wr     (hdr_wr),
		.ld         (ld.trk)
	);

	////////////////////
	// storage
	////////////////////

	channel_bank u_bank (
		.CLK40    (CLK40),
		.fifo_clr (fifo_clr),
		.grp      ({G6IN, G5IN, G4IN, G3IN, G2IN, G1IN}),  // group 0 in low bits
		.rd_en    (RD_ENA),
		.dout     (DOUT_16CH),
		.empty    (fmt),
		.any_full (ch_full),
		.ld       (ld.bank)
	);

	sync_fifo #(
		.data_t (daq_pkg::l1a_hdr_t),
		.DEPTH  (`DAQ_HDR_DEPTH)
	) u_hdr_fifo (
		.CLK40  (CLK40),
		.clr    (fifo_clr),
		.din    (hdr),
		.wr_en  (hdr_wr),
		.rd_en  (L1A_RD_EN),
		.dout   (hdr_out),
		.empty  (hdr_empty),
		.full   ()
	);

	assign L1A_SMP_OUT = hdr_out;
	assign RDY         = ~hdr_empty;  // header waiting

endmodule

// ==== dv/tb_fifo16ch_wide.sv ====
`include "daq_settings.svh"

module tb_fifo16ch_wide;

	localparam int N_RAND = 8;
	// reset, random events, overlap, back-pressure and clear phases, doubled
	localparam int CYC_LIMIT = 2 * (10 + N_RAND * 47 + 160 + 3 * 43 + 70 + 30);

	logic                   CLK40;
	logic                   RST_RESYNC;
	logic                   FIFO_RST;
	logic                   L1A;
	logic                   L1A_MATCH;
	logic                   SMPCLK;
	logic [`DAQ_SAMP_W-1:0] SAMP_MAX;
	logic [191:0]           G1IN;
	logic [191:0]           G2IN;
	logic [191:0]           G3IN;
	logic [191:0]           G4IN;
	logic [191:0]           G5IN;
	logic [191:0]           G6IN;
	logic [`DAQ_NCH-1:0]    RD_ENA;
	logic                   L1A_RD_EN;
	logic                   RDY;
	logic [43:0]            L1A_SMP_OUT;
	logic [191:0]           DOUT_16CH;
	logic [23:0]            L1A_CNT;
	logic [11:0]            L1A_MTCH_CNT;
	logic [`DAQ_NCH-1:0]    fmt;

	int                 seed = 97894;
	int                 cyc = 0;
	int                 n_val = 0;    // wrong values
	int                 n_other = 0;  // missing responses
	logic [23:0]        mdl_l1a;
	logic [11:0]        mdl_mcnt;
	daq_pkg::l1a_hdr_t  hdr_q [$];    // headers still to be read
	daq_pkg::l1a_hdr_t  exp_hdr;
	logic [191:0]       exp_dout;
	logic               chk_data;
	logic               chk_hdr;
	logic               chk_idle;

	fifo16ch_wide dut (.*);

	initial begin
		CLK40 = 1'b0;
		forever #50 CLK40 = ~CLK40;
	end

	// SMPCLK runs at a quarter of CLK40
	always @(negedge CLK40)
		SMPCLK <= cyc[1];

	always @(posedge CLK40) begin
		cyc <= cyc + 1;
		if (cyc == CYC_LIMIT) begin
			$display("run stopped at the cycle limit of %0d", CYC_LIMIT);
			$display("errors: %0d wrong values, %0d other", n_val, n_other);
			$display("test failed");
			$finish;
		end
	end

	// trigger counts as the counters should show them
	always @(posedge CLK40) begin
		if (RST_RESYNC) begin
			mdl_l1a  <= '0;
			mdl_mcnt <= '0;
		end else begin
			if (L1A)
				mdl_l1a <= mdl_l1a + 1'b1;
			if (L1A_MATCH)
				mdl_mcnt <= mdl_mcnt + 1'b1;
		end
	end

	////////////////////
	// checks
	////////////////////

	a_l1a_cnt : assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		L1A_CNT == mdl_l1a)
		else begin
			n_val++;
			$display("Fail t=%0t L1A_CNT exp %0d got %0d",
				$time, $sampled(mdl_l1a), $sampled(L1A_CNT));
		end

	a_mtch_cnt : assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		L1A_MTCH_CNT == mdl_mcnt)
		else begin
			n_val++;
			$display("Fail t=%0t L1A_MTCH_CNT exp %0d got %0d",
				$time, $sampled(mdl_mcnt), $sampled(L1A_MTCH_CNT));
		end

	a_dout : assert property (@(posedge CLK40) chk_data |-> DOUT_16CH == exp_dout)
		else begin
			n_val++;
			$display("Fail t=%0t DOUT_16CH exp %h got %h",
				$time, $sampled(exp_dout), $sampled(DOUT_16CH));
		end

	a_fmt_busy : assert property (@(posedge CLK40) chk_data |-> fmt == '0)
		else begin
			n_val++;
			$display("Fail t=%0t fmt exp %h got %h", $time, 16'h0, $sampled(fmt));
		end

	a_fmt_idle : assert property (@(posedge CLK40) chk_idle |-> fmt == '1)
		else begin
			n_val++;
			$display("Fail t=%0t fmt exp %h got %h", $time, 16'hffff, $sampled(fmt));
		end

	a_rdy_idle : assert property (@(posedge CLK40) chk_idle |-> !RDY)
		else begin
			n_val++;
			$display("Fail t=%0t RDY exp 0 got %b", $time, $sampled(RDY));
		end

	a_rdy_hdr : assert property (@(posedge CLK40) chk_hdr |-> RDY)
		else begin
			n_val++;
			$display("Fail t=%0t RDY exp 1 got %b", $time, $sampled(RDY));
		end

	a_hdr : assert property (@(posedge CLK40) chk_hdr |-> L1A_SMP_OUT == exp_hdr)
		else begin
			n_val++;
			$display("Fail t=%0t L1A_SMP_OUT exp %h got %h",
				$time, $sampled(exp_hdr), $sampled(L1A_SMP_OUT));
		end

	////////////////////
	// stimulus
	////////////////////

	// channel ch of group g carries g*16 + ch + 256*tag
	function automatic logic [191:0] bus_value(input int grp, input int tag);
		logic [191:0] v;
		for (int ch = 0; ch < `DAQ_NCH; ch++)
			v[ch*12 +: 12] = 12'(grp * 16 + ch + 256 * tag);
		return v;
	endfunction

	task automatic set_buses(input int tag);
		G1IN = bus_value(0, tag);
		G2IN = bus_value(1, tag);
		G3IN = bus_value(2, tag);
		G4IN = bus_value(3, tag);
		G5IN = bus_value(4, tag);
		G6IN = bus_value(5, tag);
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge CLK40);
	endtask

	// matched trigger, queues the header it should produce
	task automatic trigger(input logic [3:0] ovc, input logic full);
		daq_pkg::l1a_hdr_t h;
		h.multi_ovlp = (ovc > 4'd1);
		h.ovlp       = (ovc != 4'd0);
		h.smp_phase  = cyc[1];  // SMPCLK level this cycle
		h.ch_full    = full;
		h.ovlp_cnt   = ovc;
		h.match_cnt  = mdl_mcnt + 12'd1;
		h.l1a_cnt    = mdl_l1a + 24'd1;
		hdr_q.push_back(h);
		L1A       = 1'b1;
		L1A_MATCH = 1'b1;
		@(negedge CLK40);
		L1A       = 1'b0;
		L1A_MATCH = 1'b0;
	endtask

	task automatic wait_rdy();
		int n;
		n = 0;
		while (!RDY && n < 40) begin
			@(negedge CLK40);
			n++;
		end
		if (!RDY) begin
			n_other++;
			$display("no header became ready within 40 cycles of a trigger");
		end
	endtask

	task automatic read_header();
		exp_hdr   = hdr_q.pop_front();
		chk_hdr   = 1'b1;
		L1A_RD_EN = 1'b1;
		@(negedge CLK40);
		chk_hdr   = 1'b0;
		L1A_RD_EN = 1'b0;
	endtask

	// one event's words, group index restarts at 0
	task automatic drain(input int n, input int tag);
		for (int k = 0; k < n; k++) begin
			exp_dout = bus_value(k % `DAQ_NGRP, tag);
			chk_data = 1'b1;
			RD_ENA   = '1;
			@(negedge CLK40);
		end
		chk_data = 1'b0;
		RD_ENA   = '0;
	endtask

	task automatic check_idle();
		chk_idle = 1'b1;
		@(negedge CLK40);
		chk_idle = 1'b0;
	endtask

	initial begin
		int smax;
		int gap;
		RST_RESYNC = 1'b1;
		FIFO_RST   = 1'b0;
		L1A        = 1'b0;
		L1A_MATCH  = 1'b0;
		SMPCLK     = 1'b0;
		SAMP_MAX   = '0;
		RD_ENA     = '0;
		L1A_RD_EN  = 1'b0;
		chk_data   = 1'b0;
		chk_hdr    = 1'b0;
		chk_idle   = 1'b0;
		exp_dout   = '0;
		exp_hdr    = '0;
		set_buses(0);
		repeat (4) @(negedge CLK40);
		RST_RESYNC = 1'b0;
		check_idle();
		repeat (3) begin  // lone triggers
			L1A = 1'b1;
			@(negedge CLK40);
			L1A = 1'b0;
			@(negedge CLK40);
		end

		// single events, random length and spacing
		for (int e = 0; e < N_RAND; e++) begin
			smax     = $unsigned($random(seed)) % 12;
			gap      = $unsigned($random(seed)) % 8;
			SAMP_MAX = `DAQ_SAMP_W'(smax);
			set_buses(e + 1);
			repeat (gap) begin
				L1A = 1'($random(seed));
				@(negedge CLK40);
			end
			trigger(4'd0, 1'b0);
			wait_rdy();
			idle(smax + 6);
			read_header();
			drain(smax + 1, e + 1);
			check_idle();
		end

		// three events inside one load, a new bus tag for each load
		SAMP_MAX = 7;
		set_buses(9);
		trigger(4'd0, 1'b0);
		wait_rdy();            // first push, on a sample boundary
		trigger(4'd1, 1'b0);
		idle(2);
		trigger(4'd2, 1'b0);
		idle(6);               // gap between first and second load
		set_buses(10);
		idle(10);              // gap between second and third load
		set_buses(11);
		idle(12);
		repeat (3) read_header();
		drain(8, 9);
		drain(8, 10);
		drain(8, 11);
		check_idle();

		// back-pressure, nothing read until the third event
		SAMP_MAX = 31;
		for (int e = 0; e < 3; e++) begin
			set_buses(10 + e);
			trigger(4'd0, e == 2);
			idle(31 + 12);
		end
		repeat (3) read_header();
		drain(32, 10);
		drain(32, 11);
		check_idle();

		// clear with data and a header waiting
		SAMP_MAX = 3;
		set_buses(13);
		trigger(4'd0, 1'b0);
		wait_rdy();
		idle(10);
		FIFO_RST = 1'b1;
		@(negedge CLK40);
		FIFO_RST = 1'b0;
		hdr_q.delete();
		check_idle();

		idle(2);
		$display("errors: %0d wrong values, %0d other", n_val, n_other);
		if (n_val + n_other == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/daq_pkg.sv
hdl/load_if.sv
hdl/sync_fifo.sv
hdl/sample_load_ctrl.sv
hdl/l1a_tracker.sv
hdl/channel_bank.sv
hdl/fifo16ch_wide.sv
dv/tb_fifo16ch_wide.sv

// ==== Bender.yml ====
package:
  name: fifo16ch_wide

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/daq_pkg.sv
      - hdl/load_if.sv
      - hdl/sync_fifo.sv
      - hdl/sample_load_ctrl.sv
      - hdl/l1a_tracker.sv
      - hdl/channel_bank.sv
      - hdl/fifo16ch_wide.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_fifo16ch_wide.sv
